// File: common/cam_regs_pkg.sv
`default_nettype none

package cam_regs_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int ADDR_W         = 9;
    localparam int DATA_W         = 32;
    localparam int GPIO_W         = 8;
    localparam int FIFO_DEPTH     = 16;
    localparam int CNT_W          = 5;                    // Holds 0 .. FIFO_DEPTH
    localparam int PTR_W          = $clog2(FIFO_DEPTH);
    localparam int BEATS_PER_WORD = 4;
    localparam int BEAT_W         = $clog2(BEATS_PER_WORD);
    localparam int ALMOST_LVL     = 2;                    // Margin for almost flags

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    localparam logic [ADDR_W-1:0] ADR_DEVICE_ID = 9'h000;
    localparam logic [ADDR_W-1:0] ADR_REV       = 9'h001;
    localparam logic [ADDR_W-1:0] ADR_GPIO_IN   = 9'h002;
    localparam logic [ADDR_W-1:0] ADR_GPIO_OUT  = 9'h003;
    localparam logic [ADDR_W-1:0] ADR_GPIO_OE   = 9'h004;
    localparam logic [ADDR_W-1:0] ADR_FIFO_ACC  = 9'h040;
    localparam logic [ADDR_W-1:0] ADR_FIFO_FLAG = 9'h041;

    localparam logic [DATA_W-1:0] DEVICE_ID     = 32'hF1F07E57;
    localparam logic [15:0]       REV_NUM       = 16'h0100;
    localparam logic [DATA_W-1:0] DEF_REG_VALUE = 32'hFABDEFAC;  // Unmapped or empty FIFO

    // ------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic              cyc;
        logic              stb;
        logic              we;
        logic [3:0]        byte_stb;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
    } wb_rsp_t;

    typedef struct packed {
        logic vsync;
        logic href;
    } cam_in_t;

    typedef struct packed {
        logic [CNT_W-1:0] count;
        logic             empty;
        logic             full;
        logic             almost_empty;
        logic             almost_full;
    } fifo_status_t;

    typedef logic [DATA_W-1:0] cam_word_t;

endpackage

`default_nettype wire

// File: hw/wb_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module wb_reg_bank (
    input  wire                                 PCLKI,
    input  wire                                 WBs_RST_i,
    input  wire  cam_regs_pkg::wb_req_t         wb_req_i,
    input  wire  [cam_regs_pkg::GPIO_W-1:0]     gpio_in_i,
    input  wire  cam_regs_pkg::cam_word_t       fifo_head_i,
    input  wire  cam_regs_pkg::fifo_status_t    fifo_status_i,
    output cam_regs_pkg::wb_rsp_t               wb_rsp_o,
    output logic [cam_regs_pkg::GPIO_W-1:0]     gpio_out_o,
    output logic [cam_regs_pkg::GPIO_W-1:0]     gpio_oe_o,
    output logic                                pop_o
);

    import cam_regs_pkg::*;

    logic              ack_q;
    logic              ack_nxt;
    logic              rd_stb;
    logic              wr_stb;
    logic              fifo_rd_dcd;
    logic [DATA_W-1:0] flag_word;
    logic [DATA_W-1:0] rd_mux;
    logic [DATA_W-1:0] rd_dat_q;

    // ------------------------------------------------------------
    // Access decode
    // ------------------------------------------------------------
    assign ack_nxt     = wb_req_i.cyc & wb_req_i.stb & ~ack_q;  // First cycle of access
    assign rd_stb      = ack_nxt & ~wb_req_i.we;
    assign wr_stb      = ack_nxt & wb_req_i.we & wb_req_i.byte_stb[0];
    assign fifo_rd_dcd = rd_stb & (wb_req_i.adr == ADR_FIFO_ACC);

    // Flags in the low nibble and count at 12:8
    assign flag_word = {{(DATA_W-CNT_W-8){1'b0}},
                        fifo_status_i.count,
                        4'h0,
                        fifo_status_i.almost_full,
                        fifo_status_i.almost_empty,
                        fifo_status_i.full,
                        fifo_status_i.empty};

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    always_comb begin
        case (wb_req_i.adr)
            ADR_DEVICE_ID: rd_mux = DEVICE_ID;
            ADR_REV:       rd_mux = {16'h0, REV_NUM};
            ADR_GPIO_IN:   rd_mux = DATA_W'(gpio_in_i);
            ADR_GPIO_OUT:  rd_mux = DATA_W'(gpio_out_o);
            ADR_GPIO_OE:   rd_mux = DATA_W'(gpio_oe_o);
            ADR_FIFO_ACC:  rd_mux = fifo_status_i.empty ? DEF_REG_VALUE : fifo_head_i;
            ADR_FIFO_FLAG: rd_mux = flag_word;
            default:       rd_mux = DEF_REG_VALUE;
        endcase
    end

    // Read data loaded on the first cycle of a read
    always_ff @(posedge PCLKI) begin
        if (rd_stb) begin
            rd_dat_q <= rd_mux;
        end
    end

    // ------------------------------------------------------------
    // Control and GPIO registers
    // ------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i) begin
        if (WBs_RST_i) begin
            ack_q      <= 1'b0;
            pop_o      <= 1'b0;
            gpio_out_o <= '0;
            gpio_oe_o  <= '0;
        end else begin
            ack_q <= ack_nxt;
            pop_o <= fifo_rd_dcd & ~fifo_status_i.empty;  // High for the ack cycle only

            if (wr_stb && (wb_req_i.adr == ADR_GPIO_OUT)) begin
                gpio_out_o <= wb_req_i.dat[GPIO_W-1:0];
            end

            if (wr_stb && (wb_req_i.adr == ADR_GPIO_OE)) begin
                gpio_oe_o <= wb_req_i.dat[GPIO_W-1:0];
            end
        end
    end

    assign wb_rsp_o = '{dat: rd_dat_q, ack: ack_q};

endmodule

`default_nettype wire

// File: cam_capture/cam_packer.sv
`timescale 1ns/1ps
`default_nettype none

module cam_packer (
    input  wire                          PCLKI,
    input  wire                          WBs_RST_i,
    input  wire cam_regs_pkg::cam_in_t   cam_i,
    input  wire                          credit_i,
    output logic                         push_o,
    output cam_regs_pkg::cam_word_t      word_o,
    output logic                         flush_o
);

    import cam_regs_pkg::*;

    logic              beat_vld;
    logic              word_done;
    logic              has_credit;
    logic              spend;
    logic [BEAT_W-1:0] beat_cnt;
    cam_word_t         seq_num;
    logic [CNT_W-1:0]  credit_cnt;

    assign beat_vld   = cam_i.vsync & cam_i.href;
    assign word_done  = beat_vld & (beat_cnt == BEAT_W'(BEATS_PER_WORD - 1));
    assign has_credit = (credit_cnt != '0);
    assign spend      = word_done & has_credit;  // Word without credit is lost
    assign flush_o    = ~cam_i.vsync;            // Frame gap

    // ------------------------------------------------------------
    // Beat count, sequence number and credits
    // ------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i) begin
        if (WBs_RST_i) begin
            beat_cnt   <= '0;
            seq_num    <= '0;
            credit_cnt <= CNT_W'(FIFO_DEPTH);
            push_o     <= 1'b0;
        end else begin
            push_o <= spend;

            // Free running so dropped words still use a number
            if (word_done) begin
                seq_num <= seq_num + DATA_W'(1);
            end

            if (flush_o) begin
                beat_cnt   <= '0;
                credit_cnt <= CNT_W'(FIFO_DEPTH);  // FIFO empties on the same edge
            end else begin
                if (beat_vld) begin
                    beat_cnt <= word_done ? '0 : beat_cnt + BEAT_W'(1);
                end

                case ({credit_i, spend})
                    2'b10:   credit_cnt <= credit_cnt + CNT_W'(1);
                    2'b01:   credit_cnt <= credit_cnt - CNT_W'(1);
                    default: credit_cnt <= credit_cnt;  // None or both
                endcase
            end
        end
    end

    // Word payload
    always_ff @(posedge PCLKI) begin
        if (word_done) begin
            word_o <= seq_num;
        end
    end

endmodule

`default_nettype wire

// File: cam_capture/cam_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cam_fifo (
    input  wire                            PCLKI,
    input  wire                            WBs_RST_i,
    input  wire                            push_i,
    input  wire cam_regs_pkg::cam_word_t   word_i,
    input  wire                            pop_i,
    input  wire                            flush_i,
    output cam_regs_pkg::cam_word_t        head_o,
    output cam_regs_pkg::fifo_status_t     status_o,
    output logic                           credit_o
);

    import cam_regs_pkg::*;

    cam_word_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // ------------------------------------------------------------
    // Pointers and count
    // ------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i) begin
        if (WBs_RST_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;  // Flush wins over push and pop
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end

            if (pop_i) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end

            case ({push_i, pop_i})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge PCLKI) begin
        if (push_i) begin
            mem[wr_ptr] <= word_i;
        end
    end

    assign head_o   = mem[rd_ptr];        // Stale when empty
    assign credit_o = pop_i & ~flush_i;   // One slot freed per pop

    // ------------------------------------------------------------
    // Status flags from count
    // ------------------------------------------------------------
    always_comb begin
        status_o.count        = count;
        status_o.empty        = (count == '0);
        status_o.full         = (count == CNT_W'(FIFO_DEPTH));
        status_o.almost_empty = (count <= CNT_W'(ALMOST_LVL));
        status_o.almost_full  = (count >= CNT_W'(FIFO_DEPTH - ALMOST_LVL));
    end

endmodule

`default_nettype wire

// File: hw/cam_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_regs_top (
    input  wire                                 PCLKI,
    input  wire                                 WBs_RST_i,
    input  wire  cam_regs_pkg::wb_req_t         wb_req_i,
    input  wire  cam_regs_pkg::cam_in_t         cam_i,
    input  wire  [cam_regs_pkg::GPIO_W-1:0]     gpio_in_i,
    output cam_regs_pkg::wb_rsp_t               wb_rsp_o,
    output logic [cam_regs_pkg::GPIO_W-1:0]     gpio_out_o,
    output logic [cam_regs_pkg::GPIO_W-1:0]     gpio_oe_o
);

    import cam_regs_pkg::*;

    cam_word_t    fifo_head;
    fifo_status_t fifo_status;
    cam_word_t    pack_word;
    logic         pop;
    logic         push;
    logic         flush;
    logic         credit;

    // ------------------------------------------------------------
    // Register bank, packer and FIFO
    // ------------------------------------------------------------
    wb_reg_bank u_reg_bank (
        .PCLKI         (PCLKI),
        .WBs_RST_i     (WBs_RST_i),
        .wb_req_i      (wb_req_i),
        .gpio_in_i     (gpio_in_i),
        .fifo_head_i   (fifo_head),
        .fifo_status_i (fifo_status),
        .wb_rsp_o      (wb_rsp_o),
        .gpio_out_o    (gpio_out_o),
        .gpio_oe_o     (gpio_oe_o),
        .pop_o         (pop)
    );

    cam_packer u_packer (
        .PCLKI     (PCLKI),
        .WBs_RST_i (WBs_RST_i),
        .cam_i     (cam_i),
        .credit_i  (credit),     // Returned by FIFO pops
        .push_o    (push),
        .word_o    (pack_word),
        .flush_o   (flush)
    );

    cam_fifo u_fifo (
        .PCLKI     (PCLKI),
        .WBs_RST_i (WBs_RST_i),
        .push_i    (push),
        .word_i    (pack_word),
        .pop_i     (pop),
        .flush_i   (flush),
        .head_o    (fifo_head),
        .status_o  (fifo_status),
        .credit_o  (credit)
    );

endmodule

`default_nettype wire

// File: verification/cam_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cam_regs_tb;

    import cam_regs_pkg::*;

    localparam int CLK_HALF   = 4;     // 8 ns period
    localparam int DRIVE_DLY  = 1;     // Inputs change 1 ns after the edge
    localparam int MAX_CYCLES = 4000;

    logic              PCLKI;
    logic              WBs_RST_i;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    cam_in_t           cam;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;
    logic [GPIO_W-1:0] gpio_oe;

    // Reference model
    logic [GPIO_W-1:0] mdl_out;
    logic [GPIO_W-1:0] mdl_oe;
    cam_word_t         mdl_words[$];
    cam_word_t         mdl_seq;
    cam_word_t         last_pop;
    int                mdl_beat;

    // Checks waiting for the compare process
    string             chk_name[$];
    logic [DATA_W-1:0] chk_exp[$];
    logic [DATA_W-1:0] chk_act[$];
    time               chk_time[$];

    integer            seed = 32'h501;
    int                cycles = 0;
    int                n_checks = 0;
    int                n_errors = 0;
    int                n_tests = 0;
    int                test_err0 = 0;
    int                i;
    logic [DATA_W-1:0] rd;

    cam_regs_top dut0 (
        .PCLKI      (PCLKI),
        .WBs_RST_i  (WBs_RST_i),
        .wb_req_i   (wb_req),
        .cam_i      (cam),
        .gpio_in_i  (gpio_in),
        .wb_rsp_o   (wb_rsp),
        .gpio_out_o (gpio_out),
        .gpio_oe_o  (gpio_oe)
    );

    initial begin
        PCLKI = 1'b0;
        forever #CLK_HALF PCLKI = ~PCLKI;
    end

    // Watchdog
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge PCLKI);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // ------------------------------------------------------------
    // Reference function and compare process
    // ------------------------------------------------------------
    function automatic logic [DATA_W-1:0] exp_read(input logic [ADDR_W-1:0] addr);
        int c;
        c = mdl_words.size();
        case (addr)
            ADR_DEVICE_ID: return DEVICE_ID;
            ADR_REV:       return {16'h0, REV_NUM};
            ADR_GPIO_IN:   return DATA_W'(gpio_in);
            ADR_GPIO_OUT:  return DATA_W'(mdl_out);
            ADR_GPIO_OE:   return DATA_W'(mdl_oe);
            ADR_FIFO_ACC:  return (c == 0) ? DEF_REG_VALUE : mdl_words[0];
            ADR_FIFO_FLAG: return (DATA_W'(c) << 8)
                                  | (DATA_W'(c >= FIFO_DEPTH - ALMOST_LVL) << 3)
                                  | (DATA_W'(c <= ALMOST_LVL) << 2)
                                  | (DATA_W'(c == FIFO_DEPTH) << 1)
                                  | DATA_W'(c == 0);
            default:       return DEF_REG_VALUE;
        endcase
    endfunction

    initial begin : compare
        string             name;
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] act;
        time               t;
        forever begin
            wait (chk_name.size() > 0);
            name = chk_name.pop_front();
            exp  = chk_exp.pop_front();
            act  = chk_act.pop_front();
            t    = chk_time.pop_front();
            n_checks++;
            if (act !== exp) begin
                n_errors++;
                $display("Fail at %0t: %s expected 0x%08h, got 0x%08h", t, name, exp, act);
            end
        end
    end

    task automatic post(input string name, input logic [DATA_W-1:0] exp,
                        input logic [DATA_W-1:0] act);
        chk_name.push_back(name);
        chk_exp.push_back(exp);
        chk_act.push_back(act);
        chk_time.push_back($time);
    endtask

    task automatic test_done(input string name);
        wait (chk_name.size() == 0);
        n_tests++;
        $display("Test %s finished with %0d errors", name, n_errors - test_err0);
        test_err0 = n_errors;
    endtask

    // ------------------------------------------------------------
    // Bus and camera drivers
    // ------------------------------------------------------------
    task automatic step();
        @(posedge PCLKI);
        #DRIVE_DLY;
    endtask

    // Ack is due one cycle after the request
    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            step();
            n++;
        end while (!wb_rsp.ack);
        post("wb_rsp_o.ack delay", DATA_W'(1), DATA_W'(n));
    endtask

    task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [3:0] be);
        wb_req = '{adr: addr, cyc: 1'b1, stb: 1'b1, we: 1'b1, byte_stb: be, dat: data};
        wait_ack();
        step();
        post("wb_rsp_o.ack", '0, DATA_W'(wb_rsp.ack));  // One cycle wide
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        wb_req = '{adr: addr, cyc: 1'b1, stb: 1'b1, we: 1'b0, byte_stb: 4'hF, dat: '0};
        wait_ack();
        data = wb_rsp.dat;  // Valid during ack only
        step();
        post("wb_rsp_o.ack", '0, DATA_W'(wb_rsp.ack));
        wb_req = '0;
    endtask

    task automatic check_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] act;
        exp = exp_read(addr);
        wb_read(addr, act);
        post($sformatf("wb_rsp_o.dat[0x%03h]", addr), exp, act);
        if (addr == ADR_FIFO_ACC && mdl_words.size() > 0) last_pop = mdl_words.pop_front();
    endtask

    task automatic gpio_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [3:0] be);
        wb_write(addr, data, be);
        if (be[0] && addr == ADR_GPIO_OUT) mdl_out = data[GPIO_W-1:0];
        if (be[0] && addr == ADR_GPIO_OE) mdl_oe = data[GPIO_W-1:0];
        post("gpio_out_o", DATA_W'(mdl_out), DATA_W'(gpio_out));
        post("gpio_oe_o", DATA_W'(mdl_oe), DATA_W'(gpio_oe));
    endtask

    // Every fourth beat makes a word that is kept only while a slot is free
    function automatic void model_beat();
        mdl_beat++;
        if (mdl_beat == BEATS_PER_WORD) begin
            mdl_beat = 0;
            if (mdl_words.size() < FIFO_DEPTH) mdl_words.push_back(mdl_seq);
            mdl_seq++;
        end
    endfunction

    task automatic cam_beats(input int n);
        int gap;
        int b;
        for (b = 0; b < n; b++) begin
            gap = $unsigned($random(seed)) % 4;
            cam.href = 1'b0;
            repeat (gap) step();
            cam.href = 1'b1;
            model_beat();
            step();
        end
        cam.href = 1'b0;
        repeat (3) step();   // Last push lands in the FIFO
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        $timeformat(-9, 1, " ns", 10);
        wb_req    = '0;
        cam       = '0;
        gpio_in   = '0;
        WBs_RST_i = 1'b1;
        mdl_out   = '0;
        mdl_oe    = '0;
        mdl_seq   = '0;
        last_pop  = '0;
        mdl_beat  = 0;
        repeat (5) @(posedge PCLKI);
        #DRIVE_DLY;
        WBs_RST_i = 1'b0;
        step();

        gpio_in = GPIO_W'($random(seed));
        step();
        check_read(ADR_DEVICE_ID);
        check_read(ADR_REV);
        check_read(ADR_GPIO_IN);
        check_read(9'h1FF);
        post("gpio_out_o", '0, DATA_W'(gpio_out));
        post("gpio_oe_o", '0, DATA_W'(gpio_oe));
        check_read(ADR_FIFO_FLAG);
        test_done("reset");

        for (i = 0; i < 4; i++) begin
            gpio_write(ADR_GPIO_OUT, $random(seed), 4'hF);
            gpio_write(ADR_GPIO_OE, $random(seed), 4'hF);
            check_read(ADR_GPIO_OUT);
            check_read(ADR_GPIO_OE);
        end
        gpio_write(ADR_GPIO_OUT, ~DATA_W'(mdl_out), 4'hE);  // Byte 0 masked
        gpio_write(ADR_GPIO_OE, ~DATA_W'(mdl_oe), 4'hE);
        check_read(ADR_GPIO_OUT);
        check_read(ADR_GPIO_OE);
        test_done("gpio");

        cam.vsync = 1'b1;
        step();
        cam_beats(4 * 5);
        check_read(ADR_FIFO_FLAG);
        repeat (5) check_read(ADR_FIFO_ACC);
        check_read(ADR_FIFO_ACC);
        check_read(ADR_FIFO_FLAG);
        test_done("capture");

        cam_beats(4 * 20);
        check_read(ADR_FIFO_FLAG);
        repeat (FIFO_DEPTH) check_read(ADR_FIFO_ACC);
        cam_beats(4);
        wb_read(ADR_FIFO_ACC, rd);
        post("wb_rsp_o.dat[0x040] after drops", last_pop + DATA_W'(5), rd);  // Four numbers skipped
        void'(mdl_words.pop_front());
        check_read(ADR_FIFO_FLAG);
        test_done("overflow");

        cam_beats(4 * 3);
        cam_beats(2);
        cam.vsync = 1'b0;
        mdl_words.delete();
        mdl_beat = 0;
        repeat (3) step();
        cam.vsync = 1'b1;
        step();
        check_read(ADR_FIFO_FLAG);
        cam_beats(3);
        check_read(ADR_FIFO_FLAG);
        cam_beats(1);
        check_read(ADR_FIFO_FLAG);
        check_read(ADR_FIFO_ACC);
        test_done("flush");

        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cam_regs.f
common/cam_regs_pkg.sv
hw/wb_reg_bank.sv
cam_capture/cam_packer.sv
cam_capture/cam_fifo.sv
hw/cam_regs_top.sv
verification/cam_regs_tb.sv

// File: Bender.yml
package:
  name: cam_regs

sources:
  # Package first, then RTL bottom up
  - files:
      - common/cam_regs_pkg.sv
      - hw/wb_reg_bank.sv
      - cam_capture/cam_packer.sv
      - cam_capture/cam_fifo.sv
      - hw/cam_regs_top.sv

  - target: simulation
    files:
      - verification/cam_regs_tb.sv
